//--- compile.f
+incdir+common
+incdir+bench
common/cpu_pkg.sv
common/link_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
source/byte_fifo.sv
core/cpu_core.sv
source/serial_cpu_top.sv
bench/serial_cpu_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 --top-module serial_cpu_tb -f compile.f; then
	echo "Verilator build failed"
	exit 1
fi

if ! out=$(./obj_dir/Vserial_cpu_tb); then
	echo "$out"
	echo "Simulation exited with an error status"
	exit 1
fi
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- bench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef logic [7:0] bytes_t[$];
typedef logic [31:0] words_t[$];

logic [31:0] lfsr = 32'h5df9_d26b;

// Taps 32, 22, 2, 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [7:0] rand_byte();
	logic [7:0] b;
	b = '0;
	for (int i = 0; i < 8; i++) begin
		lfsr = lfsr_step(lfsr);
		b = {b[6:0], lfsr[0]}; // One step per bit.
	end
	return b;
endfunction

function automatic logic [31:0] reg_instr(input funct_e fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sh);
	return {SPECIAL, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] imm_instr(input opcode_e op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] jump_instr(input opcode_e op, input logic [25:0] target);
	return {op, target};
endfunction

// ISA model. Stops when IN finds no byte left, or after the step budget.
function automatic bytes_t expected_output(input words_t prog, input bytes_t din,
		input int steps);
	logic [31:0] r [32];
	logic [31:0] w;
	logic [31:0] sx;
	logic [15:0] imm;
	logic [`IMEM_ADDR_W-1:0] pc;
	logic [`IMEM_ADDR_W-1:0] pc_inc;
	logic [`IMEM_ADDR_W-1:0] pc_n;
	instr_t f;
	bytes_t dout;
	int k;
	for (int i = 0; i < 32; i++) r[i] = '0;
	pc = '0;
	k = 0;
	dout = {};
	for (int s = 0; s < steps; s++) begin
		w = (int'(pc) < prog.size()) ? prog[pc] : 32'h0;
		f = instr_t'(w);
		imm = w[15:0];
		sx = {{16{imm[15]}}, imm};
		pc_inc = pc + 1'b1;
		pc_n = pc_inc;
		if (f.opcode == IN && k >= din.size()) break;
		case (f.opcode)
			SPECIAL: case (f.funct)
				ADD: r[f.rd] = r[f.rs] + r[f.rt];
				SUB: r[f.rd] = r[f.rs] - r[f.rt];
				AND: r[f.rd] = r[f.rs] & r[f.rt];
				OR:  r[f.rd] = r[f.rs] | r[f.rt];
				NOR: r[f.rd] = ~(r[f.rs] | r[f.rt]);
				SLL: r[f.rd] = r[f.rt] << f.shamt;
				SRL: r[f.rd] = r[f.rt] >> f.shamt;
				SLT: r[f.rd] = {31'h0, $signed(r[f.rs]) < $signed(r[f.rt])};
				JR:  pc_n = r[f.rs][`IMEM_ADDR_W-1:0];
				default: ;
			endcase
			ADDI: r[f.rt] = r[f.rs] + sx;
			ANDI: r[f.rt] = r[f.rs] & {16'h0, imm};
			ORI:  r[f.rt] = r[f.rs] | {16'h0, imm};
			SLTI: r[f.rt] = {31'h0, $signed(r[f.rs]) < $signed(sx)};
			LUI:  r[f.rt] = {imm, 16'h0};
			BEQ: if (r[f.rs] == r[f.rt]) pc_n = pc + imm[`IMEM_ADDR_W-1:0];
			BNE: if (r[f.rs] != r[f.rt]) pc_n = pc + imm[`IMEM_ADDR_W-1:0];
			J: pc_n = w[`IMEM_ADDR_W-1:0];
			JAL: begin
				r[31] = 32'(pc_inc);
				pc_n = w[`IMEM_ADDR_W-1:0];
			end
			IN: begin
				r[f.rt] = {24'h0, din[k]};
				k++;
			end
			OUT: dout.push_back(r[f.rt][7:0]);
			default: ;
		endcase
		r[0] = '0;
		pc = pc_n;
	end
	return dout;
endfunction

`endif

//--- bench/serial_cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module serial_cpu_tb import cpu_pkg::*; ();

	localparam int WAIT_LIMIT = 1000;
	localparam int DRAIN_LIMIT = 60 * 10 * `CLKS_PER_BIT;

	logic CLK = 1'b0;
	logic rst_n;
	logic rx;
	logic tx;
	logic load_sw;
	logic exec_sw;
	mode_e mode;
	logic overflow;

	logic [7:0] exp_q[$];
	logic [7:0] seen_q[$];
	logic [7:0] got;
	logic [7:0] want;
	int mismatch_cnt = 0;
	int check_cnt = 0;
	int timeout_cnt = 0;

	`include "tb_model.svh"

	always #2 CLK = ~CLK;

	serial_cpu_top dut_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.rx(rx),
		.tx(tx),
		.load_sw(load_sw),
		.exec_sw(exec_sw),
		.mode(mode),
		.overflow(overflow)
	);

	// Start bit, eight data bits LSB first, stop bit.
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge CLK);
			rx <= frame[i];
			repeat (`CLKS_PER_BIT - 1) @(posedge CLK);
		end
	endtask

	task automatic wait_mode(input mode_e m);
		int n;
		n = 0;
		while (mode !== m && n < WAIT_LIMIT) begin
			@(negedge CLK);
			n++;
		end
		if (mode !== m) begin
			timeout_cnt++;
			$display("Timeout waiting for mode %s at %0t", m.name(), $time);
		end
	endtask

	task automatic wait_overflow();
		int n;
		n = 0;
		while (overflow !== 1'b1 && n < DRAIN_LIMIT) begin
			@(negedge CLK);
			n++;
		end
		if (overflow !== 1'b1) begin
			timeout_cnt++;
			$display("Timeout waiting for the FIFO overflow flag at %0t", $time);
		end
	endtask

	// Waits until every expected byte came out, then watches for strays.
	task automatic wait_drain();
		int n;
		n = 0;
		while ((exp_q.size() != 0 || seen_q.size() != 0) && n < DRAIN_LIMIT) begin
			@(negedge CLK);
			n++;
		end
		if (exp_q.size() != 0) begin
			timeout_cnt++;
			$display("Timeout with %0d expected bytes missing on tx at %0t",
				exp_q.size(), $time);
			exp_q.delete();
		end
		repeat (12 * `CLKS_PER_BIT) @(negedge CLK);
	endtask

	task automatic load_program(input words_t p);
		logic [31:0] word;
		if (mode !== LOAD) begin
			@(posedge CLK);
			load_sw <= 1'b1;
			wait_mode(LOAD);
			@(posedge CLK);
			load_sw <= 1'b0;
		end
		for (int i = 0; i < p.size(); i++) begin
			word = p[i];
			for (int b = 0; b < 4; b++) send_byte(word[8*b +: 8]);
		end
		repeat (2 * `CLKS_PER_BIT) @(posedge CLK); // Last byte reaches the loader.
		@(posedge CLK);
		exec_sw <= 1'b1;
		wait_mode(EXEC);
		@(posedge CLK);
		exec_sw <= 1'b0;
	endtask

	task automatic queue_expected(input bytes_t b);
		for (int i = 0; i < b.size(); i++) exp_q.push_back(b[i]);
	endtask

	// Serial monitor on tx.
	initial begin : tx_monitor
		logic [7:0] b;
		b = '0;
		forever begin
			@(negedge CLK);
			if (tx === 1'b0) begin
				repeat (`CLKS_PER_BIT / 2) @(negedge CLK);
				for (int i = 0; i < 8; i++) begin
					repeat (`CLKS_PER_BIT) @(negedge CLK);
					b[i] = tx;
				end
				repeat (`CLKS_PER_BIT) @(negedge CLK);
				assert (tx === 1'b1) else begin
					check_cnt++;
					$display("Stop bit missing on tx at %0t", $time);
				end
				seen_q.push_back(b);
			end
		end
	end

	always @(negedge CLK) begin
		if (seen_q.size() != 0) begin
			got = seen_q.pop_front();
			assert (exp_q.size() != 0) else begin
				mismatch_cnt++;
				$display("Unexpected byte %02h on tx at %0t", got, $time);
			end
			if (exp_q.size() != 0) begin
				want = exp_q.pop_front();
				assert (got === want) else begin
					mismatch_cnt++;
					$display("[FAIL] %0t: tx byte %02h, expected %02h", $time, got, want);
				end
			end
		end
	end

	initial begin : main
		words_t prog;
		bytes_t din;
		rst_n <= 1'b0;
		rx <= 1'b1;
		load_sw <= 1'b0;
		exec_sw <= 1'b0;
		repeat (10) @(posedge CLK);
		rst_n <= 1'b1;

		// Idle state after reset.
		for (int i = 0; i < 4 * `CLKS_PER_BIT; i++) begin
			@(negedge CLK);
			assert (tx === 1'b1 && mode === LOAD && overflow === 1'b0) else begin
				check_cnt++;
				$display("[FAIL] %0t: reset state tx=%b mode=%b overflow=%b",
					$time, tx, mode, overflow);
			end
		end

		// ALU and immediate ops.
		prog = {};
		prog.push_back(imm_instr(ADDI, 5'd1, 5'd0, 16'h1234));
		prog.push_back(imm_instr(LUI, 5'd2, 5'd0, 16'hA5C3));
		prog.push_back(imm_instr(ORI, 5'd2, 5'd2, 16'h0F0F));
		prog.push_back(reg_instr(ADD, 5'd3, 5'd1, 5'd2, 5'd0));
		prog.push_back(reg_instr(SUB, 5'd4, 5'd1, 5'd2, 5'd0));
		prog.push_back(reg_instr(AND, 5'd5, 5'd1, 5'd2, 5'd0));
		prog.push_back(reg_instr(OR, 5'd6, 5'd1, 5'd2, 5'd0));
		prog.push_back(reg_instr(NOR, 5'd7, 5'd1, 5'd2, 5'd0));
		prog.push_back(reg_instr(SLL, 5'd8, 5'd0, 5'd2, 5'd4));
		prog.push_back(reg_instr(SRL, 5'd9, 5'd0, 5'd2, 5'd12));
		prog.push_back(reg_instr(SLT, 5'd10, 5'd2, 5'd1, 5'd0)); // Negative versus positive.
		prog.push_back(imm_instr(SLTI, 5'd11, 5'd1, 16'hFFFB));
		prog.push_back(imm_instr(ANDI, 5'd12, 5'd2, 16'hFF3C));
		prog.push_back(imm_instr(ADDI, 5'd13, 5'd0, 16'hFFFD));
		for (int i = 1; i <= 13; i++) prog.push_back(imm_instr(OUT, 5'(i), 5'd0, 16'h0));
		prog.push_back(jump_instr(J, 26'(prog.size())));
		din = {};
		queue_expected(expected_output(prog, din, 100));
		load_program(prog);
		wait_drain();

		// Echo loop fed from the serial line.
		prog = {};
		prog.push_back(imm_instr(IN, 5'd1, 5'd0, 16'h0));
		prog.push_back(imm_instr(ADDI, 5'd1, 5'd1, 16'h0001));
		prog.push_back(imm_instr(OUT, 5'd1, 5'd0, 16'h0));
		prog.push_back(jump_instr(J, 26'd0));
		load_program(prog);
		din = {};
		for (int i = 0; i < 20; i++) din.push_back(rand_byte());
		queue_expected(expected_output(prog, din, 200));
		for (int i = 0; i < din.size(); i++) send_byte(din[i]);
		wait_drain();

		// Countdown through a subroutine.
		prog = {};
		prog.push_back(imm_instr(ADDI, 5'd1, 5'd0, 16'd5));
		prog.push_back(jump_instr(JAL, 26'd5));
		prog.push_back(imm_instr(ADDI, 5'd1, 5'd1, 16'hFFFF));
		prog.push_back(imm_instr(BNE, 5'd0, 5'd1, 16'hFFFE));
		prog.push_back(imm_instr(BEQ, 5'd0, 5'd0, 16'h0)); // Spin.
		prog.push_back(imm_instr(OUT, 5'd1, 5'd0, 16'h0));
		prog.push_back(imm_instr(ADDI, 5'd3, 5'd1, 16'h0040));
		prog.push_back(imm_instr(OUT, 5'd3, 5'd0, 16'h0));
		prog.push_back(reg_instr(JR, 5'd0, 5'd31, 5'd0, 5'd0));
		din = {};
		queue_expected(expected_output(prog, din, 100));
		load_program(prog);
		wait_drain();

		// Reload with a shorter program.
		prog = {};
		prog.push_back(imm_instr(ADDI, 5'd5, 5'd0, 16'h0077));
		prog.push_back(imm_instr(OUT, 5'd5, 5'd0, 16'h0));
		prog.push_back(imm_instr(ADDI, 5'd5, 5'd5, 16'h0011));
		prog.push_back(imm_instr(OUT, 5'd5, 5'd0, 16'h0));
		prog.push_back(jump_instr(J, 26'd4));
		queue_expected(expected_output(prog, din, 50));
		load_program(prog);
		wait_drain();

		// Program that never reads, so the FIFO fills.
		prog = {};
		prog.push_back(jump_instr(J, 26'd0));
		load_program(prog);
		for (int i = 0; i < `FIFO_DEPTH; i++) send_byte(rand_byte());
		repeat (`CLKS_PER_BIT) @(negedge CLK);
		assert (overflow === 1'b0) else begin
			check_cnt++;
			$display("[FAIL] %0t: overflow flag set before the FIFO was full", $time);
		end
		for (int i = 0; i < 2; i++) send_byte(rand_byte());
		wait_overflow();
		repeat (4 * `CLKS_PER_BIT) @(negedge CLK);
		assert (overflow === 1'b1) else begin
			check_cnt++;
			$display("[FAIL] %0t: overflow flag cleared without reset", $time);
		end
		wait_drain();

		$display("Errors: %0d mismatches, %0d check failures, %0d timeouts",
			mismatch_cnt, check_cnt, timeout_cnt);
		if (mismatch_cnt + check_cnt + timeout_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- source/serial_cpu_top.sv
`timescale 1ns/1ps

module serial_cpu_top import cpu_pkg::*, link_pkg::*; (
	input  logic  CLK,
	input  logic  rst_n,
	input  logic  rx,
	output logic  tx,
	input  logic  load_sw,
	input  logic  exec_sw,
	output mode_e mode,
	output logic  overflow
);
	logic rx_valid;
	byte_t rx_byte;
	logic in_valid;
	byte_t in_byte;
	logic in_ready;
	logic out_valid;
	byte_t out_byte;
	logic out_ready;

	uart_rx uart_rx_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.rx(rx),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte)
	);

	// No back-pressure toward the line.
	byte_fifo byte_fifo_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.push_valid(rx_valid),
		.push_byte(rx_byte),
		.pop_valid(in_valid),
		.pop_byte(in_byte),
		.pop_ready(in_ready),
		.overflow(overflow)
	);

	cpu_core cpu_core_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.load_sw(load_sw),
		.exec_sw(exec_sw),
		.mode(mode),
		.in_valid(in_valid),
		.in_byte(in_byte),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_byte(out_byte),
		.out_ready(out_ready)
	);

	uart_tx uart_tx_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.out_valid(out_valid),
		.out_byte(out_byte),
		.out_ready(out_ready),
		.tx(tx)
	);

endmodule

//--- core/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_core import cpu_pkg::*, link_pkg::*; (
	input  logic  CLK,
	input  logic  rst_n,
	input  logic  load_sw,
	input  logic  exec_sw,
	output mode_e mode,
	input  logic  in_valid,
	input  byte_t in_byte,
	output logic  in_ready,
	output logic  out_valid,
	output byte_t out_byte,
	input  logic  out_ready
);
	localparam int AW = `IMEM_ADDR_W;

	logic [31:0] imem [2**AW];
	logic [31:0] regs [32];
	logic [AW-1:0] pc;
	logic [AW-1:0] pc_plus_1;
	logic [AW-1:0] pc_next;
	logic [1:0] lane;
	logic enter_load;
	logic enter_exec;
	logic load_take;
	logic [31:0] instr_w;
	instr_t instr;
	opcode_e op;
	funct_e fn;
	logic [15:0] imm;
	logic [31:0] simm;
	logic [31:0] uimm;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic wr_en;
	logic [4:0] wr_idx;
	logic [31:0] wr_data;

	assign instr_w = imem[pc];
	assign instr = instr_t'(instr_w);
	assign op = opcode_e'(instr.opcode);
	assign fn = funct_e'(instr.funct);
	assign imm = {instr.rd, instr.shamt, instr.funct};
	assign simm = {{16{imm[15]}}, imm};
	assign uimm = {16'b0, imm};
	assign pc_plus_1 = pc + 1'b1;

	assign rs_val = (instr.rs == 5'd0) ? '0 : regs[instr.rs]; // r0 reads zero.
	assign rt_val = (instr.rt == 5'd0) ? '0 : regs[instr.rt];

	assign enter_load = load_sw && (mode == EXEC);
	assign enter_exec = !load_sw && exec_sw && (mode == LOAD);
	assign load_take = (mode == LOAD) && in_valid && in_ready;

	// Loader takes every byte unless a mode switch is pending.
	assign in_ready = (mode == LOAD) ? !enter_exec : (op == IN);
	assign out_valid = (mode == EXEC) && (op == OUT);
	assign out_byte = rt_val[7:0];

	always_comb begin
		wr_en = 1'b0;
		wr_idx = instr.rt;
		wr_data = '0;
		pc_next = pc_plus_1;
		case (op)
			SPECIAL: begin
				wr_en = 1'b1;
				wr_idx = instr.rd;
				case (fn)
					ADD: wr_data = rs_val + rt_val;
					SUB: wr_data = rs_val - rt_val;
					AND: wr_data = rs_val & rt_val;
					OR:  wr_data = rs_val | rt_val;
					NOR: wr_data = ~(rs_val | rt_val);
					SLL: wr_data = rt_val << instr.shamt;
					SRL: wr_data = rt_val >> instr.shamt;
					SLT: wr_data = {31'b0, $signed(rs_val) < $signed(rt_val)};
					JR: begin
						wr_en = 1'b0;
						pc_next = rs_val[AW-1:0];
					end
					default: wr_en = 1'b0;
				endcase
			end
			ADDI: begin
				wr_en = 1'b1;
				wr_data = rs_val + simm;
			end
			ANDI: begin
				wr_en = 1'b1;
				wr_data = rs_val & uimm;
			end
			ORI: begin
				wr_en = 1'b1;
				wr_data = rs_val | uimm;
			end
			SLTI: begin
				wr_en = 1'b1;
				wr_data = {31'b0, $signed(rs_val) < $signed(simm)};
			end
			LUI: begin
				wr_en = 1'b1;
				wr_data = {imm, 16'b0};
			end
			BEQ: if (rs_val == rt_val) pc_next = pc + simm[AW-1:0]; // Relative to own address.
			BNE: if (rs_val != rt_val) pc_next = pc + simm[AW-1:0];
			J: pc_next = instr_w[AW-1:0];
			JAL: begin
				pc_next = instr_w[AW-1:0];
				wr_en = 1'b1;
				wr_idx = 5'd31;
				wr_data = 32'(pc_plus_1);
			end
			IN: begin
				wr_en = in_valid;
				wr_data = {24'b0, in_byte};
				if (!in_valid) pc_next = pc; // Wait for a byte.
			end
			OUT: if (!out_ready) pc_next = pc;
			default: wr_en = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			mode <= LOAD;
			pc <= '0;
			lane <= '0;
		end else if (enter_load) begin
			mode <= LOAD;
			pc <= '0;
			lane <= '0;
		end else if (enter_exec) begin
			mode <= EXEC;
			pc <= '0;
		end else if (mode == LOAD) begin
			if (load_take) {pc, lane} <= {pc, lane} + 1'b1;
		end else begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge CLK) begin
		if (load_take) imem[pc][{lane, 3'b000} +: 8] <= in_byte; // LSB first.
	end

	always_ff @(posedge CLK) begin
		if (mode == EXEC && wr_en) regs[wr_idx] <= wr_data;
	end

	// Stalled OUT keeps its byte on the stream.
	a_out_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		out_valid && !out_ready && !load_sw |=> out_valid && $stable(out_byte));

endmodule

//--- source/byte_fifo.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module byte_fifo import link_pkg::*; #(
	parameter int DEPTH = `FIFO_DEPTH
) (
	input  logic  CLK,
	input  logic  rst_n,
	input  logic  push_valid,
	input  byte_t push_byte,
	output logic  pop_valid,
	output byte_t pop_byte,
	input  logic  pop_ready,
	output logic  overflow
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);
	localparam logic [CW-1:0] FULL = CW'(DEPTH);

	byte_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic push_ok;
	logic pop_ok;

	assign pop_valid = (count != '0);
	assign pop_byte = mem[rd_ptr];
	assign push_ok = push_valid && (count != FULL);
	assign pop_ok = pop_valid && pop_ready;

	always_ff @(posedge CLK) begin
		if (push_ok) mem[wr_ptr] <= push_byte;
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (push_ok) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (pop_ok) rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			count <= count + CW'(push_ok) - CW'(pop_ok);
			if (push_valid && !push_ok) overflow <= 1'b1; // Sticky until reset.
		end
	end

	a_count_bound: assert property (@(posedge CLK) disable iff (!rst_n)
		count <= FULL);

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module uart_tx import link_pkg::*; (
	input  logic  CLK,
	input  logic  rst_n,
	input  logic  out_valid,
	input  byte_t out_byte,
	output logic  out_ready,
	output logic  tx
);
	localparam int CNT_W = $clog2(`CLKS_PER_BIT) + 1;
	localparam logic [CNT_W-1:0] BIT_END = CNT_W'(`CLKS_PER_BIT - 1);

	tx_state_e state;
	logic [CNT_W-1:0] cnt;
	logic [2:0] bit_idx;
	byte_t shift;
	logic bit_done;

	assign out_ready = (state == TX_IDLE);
	assign bit_done = (cnt == BIT_END);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			tx <= 1'b1;
		end else begin
			cnt <= bit_done ? '0 : cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					cnt <= '0;
					if (out_valid) begin
						tx <= 1'b0;
						state <= TX_START;
					end
				end
				TX_START: if (bit_done) begin
					tx <= shift[0];
					bit_idx <= '0;
					state <= TX_DATA;
				end
				TX_DATA: if (bit_done) begin
					bit_idx <= bit_idx + 1'b1;
					tx <= (bit_idx == 3'd7) ? 1'b1 : shift[0];
					if (bit_idx == 3'd7) state <= TX_STOP;
				end
				TX_STOP: if (bit_done) state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == TX_IDLE && out_valid) shift <= out_byte;
		else if ((state == TX_START || state == TX_DATA) && bit_done) shift <= shift >> 1;
	end

	// Whole frame passes before the next byte is taken.
	a_busy_frame: assert property (@(posedge CLK) disable iff (!rst_n)
		out_valid && out_ready |=> !out_ready [*10*`CLKS_PER_BIT]);

endmodule

//--- uart/uart_rx.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module uart_rx import link_pkg::*; (
	input  logic  CLK,
	input  logic  rst_n,
	input  logic  rx,
	output logic  rx_valid,
	output byte_t rx_byte
);
	localparam int CNT_W = $clog2(`CLKS_PER_BIT) + 1;
	localparam logic [CNT_W-1:0] BIT_END = CNT_W'(`CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_END = CNT_W'(`CLKS_PER_BIT / 2 - 1);

	rx_state_e state;
	logic [CNT_W-1:0] cnt;
	logic [2:0] bit_idx;
	logic rx_meta;
	logic rx_sync;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1; // Idle line level.
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			cnt <= cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					cnt <= '0;
					if (!rx_sync) state <= RX_START;
				end
				RX_START: if (cnt == HALF_END) begin
					cnt <= '0;
					bit_idx <= '0;
					state <= rx_sync ? RX_IDLE : RX_DATA; // Glitch, not a start bit.
				end
				RX_DATA: if (cnt == BIT_END) begin
					cnt <= '0;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7) state <= RX_STOP;
				end
				RX_STOP: if (cnt == BIT_END) begin
					state <= RX_IDLE;
					rx_valid <= rx_sync; // Framing error drops the byte.
				end
			endcase
		end
	end

	// LSB arrives first.
	always_ff @(posedge CLK) begin
		if (state == RX_DATA && cnt == BIT_END) rx_byte <= {rx_sync, rx_byte[7:1]};
	end

endmodule

//--- common/link_pkg.sv
package link_pkg;

	typedef logic [7:0] byte_t;

	// Receiver frame phases.
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	// Transmitter frame phases.
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

endpackage

//--- common/cpu_pkg.sv
package cpu_pkg;

	// MIPS-style word. I-type immediate is {rd, shamt, funct}.
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_t;

	typedef enum logic [5:0] {
		SPECIAL = 6'b000000,
		J       = 6'b000010,
		JAL     = 6'b000011,
		BEQ     = 6'b000100,
		BNE     = 6'b000101,
		ADDI    = 6'b001000,
		SLTI    = 6'b001010,
		ANDI    = 6'b001100,
		ORI     = 6'b001101,
		LUI     = 6'b001111,
		IN      = 6'b011010, // Byte from the RX stream.
		OUT     = 6'b011011  // Byte to the TX stream.
	} opcode_e;

	typedef enum logic [5:0] {
		SLL = 6'b000000,
		SRL = 6'b000010,
		JR  = 6'b001000,
		ADD = 6'b100000,
		SUB = 6'b100010,
		AND = 6'b100100,
		OR  = 6'b100101,
		NOR = 6'b100111,
		SLT = 6'b101010
	} funct_e;

	typedef enum logic {
		LOAD = 1'b0,
		EXEC = 1'b1
	} mode_e;

endpackage

//--- common/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Instruction memory address width in words.
`define IMEM_ADDR_W 8

// Bytes held between the receiver and the core.
`define FIFO_DEPTH 16

// Clock cycles per serial bit, both directions.
// Must be even so the receiver can find mid-bit.
`define CLKS_PER_BIT 8

`endif
